//--- flist.f
hdl/mipsPkg.sv
hdl/busPkg.sv
hdl/regFile.sv
hdl/timer.sv
hdl/busBridge.sv
hdl/busReadBack.sv
hdl/cpu.sv
hdl/mipsSoc.sv
tb/tbMipsSoc.sv

//--- hdl/busBridge.sv
//**************************************************************************
// Write decode from the core to the timers or the external port. Only the
// low 4 address bits reach a timer. timerSel is one-hot, all zero = extern.
//**************************************************************************
module busBridge (
    input  logic [31:0]                   memAddr,
    input  logic [31:0]                   memWData,
    input  logic                          memWe,
    output logic [busPkg::NUM_TIMERS-1:0] timerWe,
    output logic [3:0]                    regAddr,
    output logic [31:0]                   wData,
    output logic [31:0]                   extAddr,
    output logic [31:0]                   extWData,
    output logic                          extWe,
    output logic [busPkg::NUM_TIMERS-1:0] timerSel
);
    import busPkg::*;

    // Window k spans TIMER_BASE + k*TIMER_STRIDE up to the next window
    always_comb begin
        for (int k = 0; k < NUM_TIMERS; k++) begin
            timerSel[k] = (memAddr >= TIMER_BASE + TIMER_STRIDE * 32'(k)) &&
                          (memAddr <  TIMER_BASE + TIMER_STRIDE * 32'(k + 1));
        end
    end

    assign timerWe  = timerSel & {NUM_TIMERS{memWe}};
    assign extWe    = memWe && (timerSel == '0);
    assign regAddr  = memAddr[3:0];
    assign wData    = memWData;
    assign extAddr  = memAddr;
    assign extWData = memWData;

    always_comb begin
        assert final ($onehot0({timerWe, extWe}))
            else $error("bus write decoded to more than one target");
    end

endmodule

//--- hdl/busPkg.sv
//**************************************************************************
// System bus map. Word accesses only; each timer owns a 16-byte window
// starting at TIMER_BASE, anything else belongs to the external port.
//**************************************************************************
package busPkg;

    localparam int NUM_TIMERS = 2;

    localparam logic [31:0] TIMER_BASE   = 32'h0000_7F00;
    localparam logic [31:0] TIMER_STRIDE = 32'd16;

    // Register offsets inside a timer window
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_PRESET = 4'h4;
    localparam logic [3:0] REG_COUNT  = 4'h8;

    // Control register bits
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_RELOAD_BIT = 1;

endpackage

//--- hdl/busReadBack.sv
//**************************************************************************
// MEM/WB load register. Captures the word picked by timerSel every cycle;
// the core only consumes it while a lw sits in WB.
//**************************************************************************
module busReadBack (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [busPkg::NUM_TIMERS-1:0]       timerSel,
    input  logic [busPkg::NUM_TIMERS-1:0][31:0] timerRData,
    input  logic [31:0]                         extRData,
    output logic [31:0]                         loadData
);
    import busPkg::*;

    logic [31:0] selData;

    // External port unless one timer window is hit
    always_comb begin
        selData = extRData;
        for (int k = 0; k < NUM_TIMERS; k++) begin
            if (timerSel[k]) begin
                selData = timerRData[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            loadData <= 32'd0;
        end else begin
            loadData <= selData;
        end
    end

endmodule

//--- hdl/cpu.sv
//**************************************************************************
// Five-stage MIPS core with one branch delay slot, branches resolved in ID.
// Load data arrives registered from the bus in WB, so lw -> beq on the same
// register stalls twice; every other load-use case stalls once.
//**************************************************************************
module cpu (
    input  logic              clk,
    input  logic              rstN,
    input  mipsPkg::instrWord instr,
    input  logic [31:0]       loadData,
    output logic [31:0]       instrAddr,
    output logic [31:0]       memAddr,
    output logic [31:0]       memWData,
    output logic              memWe
);
    import mipsPkg::*;

    logic [31:0] pc, nextPc, idPcPlus4;
    instrWord    idInstr;

    // Decode
    logic [5:0]  op, funct;
    logic [4:0]  rs, rt, rd, dest;
    logic [15:0] imm;
    logic [31:0] immExt, rData1, rData2, idRsVal, idRtVal;
    logic [1:0]  idAluOp;
    logic        isAddu, isSubu, isOri, isLui, isLw, isSw, isBeq, isJ;
    logic        useRs, useRt, idWrite, stall;
    logic        rsHitEx, rtHitEx, rsHitMem, rtHitMem;

    // ID/EX
    logic [1:0]  exAluOp;
    logic        exUseImm, exIsLw, exIsSw, exWrite, exReady;
    logic [4:0]  exDest, exRs, exRt;
    logic [31:0] exRsVal, exRtVal, exImm, exResult;
    logic [31:0] opA, opB, aluB, aluOut, exOut;

    // EX/MEM and MEM/WB
    logic        memIsLw, memWrite, memReady;
    logic [4:0]  memDest;
    logic [31:0] memResult;
    logic        wbIsLw, wbWrite;
    logic [4:0]  wbDest;
    logic [31:0] wbResult, wbData;

    // IF
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= RESET_PC;
            idInstr <= NOP_WORD;
        end else if (!stall) begin
            pc      <= nextPc;
            idInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            idPcPlus4 <= pc + 32'd4;
        end
    end

    // ID
    assign op    = idInstr.r.op;
    assign funct = idInstr.r.funct;
    assign rs    = idInstr.i.rs;
    assign rt    = idInstr.i.rt;
    assign rd    = idInstr.r.rd;
    assign imm   = idInstr.i.imm16;

    assign isAddu = (op == OP_RTYPE) && (funct == FUNCT_ADDU);
    assign isSubu = (op == OP_RTYPE) && (funct == FUNCT_SUBU);
    assign isOri  = (op == OP_ORI);
    assign isLui  = (op == OP_LUI);
    assign isLw   = (op == OP_LW);
    assign isSw   = (op == OP_SW);
    assign isBeq  = (op == OP_BEQ);
    assign isJ    = (op == OP_J);

    assign useRs   = isAddu || isSubu || isOri || isLw || isSw || isBeq;
    assign useRt   = isAddu || isSubu || isSw || isBeq;
    assign dest    = (isAddu || isSubu) ? rd : rt;
    assign idWrite = (isAddu || isSubu || isOri || isLui || isLw) && (dest != 5'd0);
    assign immExt  = isOri ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign idAluOp = isSubu ? ALU_SUB : (isOri ? ALU_OR : ALU_ADD);

    regFile i_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rAddr1 (rs),
        .rAddr2 (rt),
        .wEn    (wbWrite),
        .wAddr  (wbDest),
        .wData  (wbData),
        .rData1 (rData1),
        .rData2 (rData2)
    );

    // Only ready results are forwarded; WB goes through the regfile bypass
    assign idRsVal = (exWrite && exDest == rs && exReady) ? exResult :
                     (memWrite && memDest == rs && memReady) ? memResult : rData1;
    assign idRtVal = (exWrite && exDest == rt && exReady) ? exResult :
                     (memWrite && memDest == rt && memReady) ? memResult : rData2;

    assign rsHitEx  = useRs && exWrite && exDest == rs;
    assign rtHitEx  = useRt && exWrite && exDest == rt;
    assign rsHitMem = useRs && memWrite && memDest == rs;
    assign rtHitMem = useRt && memWrite && memDest == rt;

    // beq needs its operands now, everything else one cycle later in EX
    assign stall = (isBeq && (((rsHitEx || rtHitEx) && !exReady) ||
                              ((rsHitMem || rtHitMem) && !memReady))) ||
                   (exIsLw && (rsHitEx || rtHitEx));

    always_comb begin
        if (isJ) begin
            nextPc = {idPcPlus4[31:28], idInstr[25:0], 2'b00};
        end else if (isBeq && idRsVal == idRtVal) begin
            nextPc = idPcPlus4 + {{14{imm[15]}}, imm, 2'b00};
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            exAluOp  <= ALU_ADD;
            exUseImm <= 1'b0;
            exIsLw   <= 1'b0;
            exIsSw   <= 1'b0;
            exWrite  <= 1'b0;
            exReady  <= 1'b0;
            exDest   <= 5'd0;
        end else begin
            exAluOp  <= idAluOp;
            exUseImm <= isOri || isLw || isSw;
            exIsLw   <= isLw;
            exIsSw   <= isSw;
            exWrite  <= idWrite;
            exReady  <= isLui;
            exDest   <= dest;
        end
    end

    always_ff @(posedge clk) begin
        exRs     <= rs;
        exRt     <= rt;
        exRsVal  <= idRsVal;
        exRtVal  <= idRtVal;
        exImm    <= immExt;
        exResult <= {imm, 16'd0};
    end

    // EX
    assign opA = (memWrite && memDest == exRs && memReady) ? memResult :
                 (wbWrite && wbDest == exRs) ? wbData : exRsVal;
    assign opB = (memWrite && memDest == exRt && memReady) ? memResult :
                 (wbWrite && wbDest == exRt) ? wbData : exRtVal;
    assign aluB = exUseImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            ALU_ADD: aluOut = opA + aluB;
            ALU_SUB: aluOut = opA - aluB;
            ALU_OR:  aluOut = opA | aluB;
            default: aluOut = 32'd0;
        endcase
    end

    assign exOut = exReady ? exResult : aluOut;

    // MEM
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memIsLw  <= 1'b0;
            memWe    <= 1'b0;
            memWrite <= 1'b0;
            memReady <= 1'b0;
            memDest  <= 5'd0;
        end else begin
            memIsLw  <= exIsLw;
            memWe    <= exIsSw;
            memWrite <= exWrite;
            memReady <= !exIsLw;
            memDest  <= exDest;
        end
    end

    always_ff @(posedge clk) begin
        memResult <= exOut;
        memWData  <= opB;
    end

    assign memAddr = memResult;

    // WB
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbIsLw  <= 1'b0;
            wbWrite <= 1'b0;
            wbDest  <= 5'd0;
        end else begin
            wbIsLw  <= memIsLw;
            wbWrite <= memWrite;
            wbDest  <= memDest;
        end
    end

    always_ff @(posedge clk) begin
        wbResult <= memResult;
    end

    assign wbData = wbIsLw ? loadData : wbResult;

    // Load-use bubble is a single cycle unless a branch waits on the load
    assert property (@(posedge clk) disable iff (!rstN) stall && !isBeq |=> !stall)
        else $error("load-use stall longer than one cycle");

    // The bubble reaches MEM two cycles after the stall
    assert property (@(posedge clk) disable iff (!rstN) stall |=> ##1 !memWe)
        else $error("store strobe raised by a pipeline bubble");

endmodule

//--- hdl/mipsPkg.sv
//**************************************************************************
// Instruction set of the reduced MIPS core: addu, subu, ori, lui, lw, sw,
// beq and j only. Every other opcode decodes as a no-op.
//**************************************************************************
package mipsPkg;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;

    // Funct codes under OP_RTYPE
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;

    // ALU operation select carried from ID into EX
    localparam logic [1:0] ALU_ADD = 2'd0;
    localparam logic [1:0] ALU_SUB = 2'd1;
    localparam logic [1:0] ALU_OR  = 2'd2;

    localparam logic [31:0] RESET_PC = 32'h0000_3000;
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

    // Same word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } instrWord;

endpackage

//--- hdl/mipsSoc.sv
//**************************************************************************
// SoC top: core, bus bridge, NUM_TIMERS timers and the load register.
// Instruction memory and data memory live outside on the two ports.
//**************************************************************************
module mipsSoc (
    input  logic                          clk,
    input  logic                          rstN,
    input  mipsPkg::instrWord             instr,
    input  logic [31:0]                   extRData,
    output logic [31:0]                   instrAddr,
    output logic [31:0]                   extAddr,
    output logic [31:0]                   extWData,
    output logic                          extWe,
    output logic [busPkg::NUM_TIMERS-1:0] irq
);
    import busPkg::*;

    logic [31:0]                  memAddr, memWData, loadData, wData;
    logic                         memWe;
    logic [3:0]                   regAddr;
    logic [NUM_TIMERS-1:0]        timerWe, timerSel;
    logic [NUM_TIMERS-1:0][31:0]  timerRData;

    cpu i_cpu (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .loadData  (loadData),
        .instrAddr (instrAddr),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .memWe     (memWe)
    );

    busBridge i_busBridge (
        .memAddr  (memAddr),
        .memWData (memWData),
        .memWe    (memWe),
        .timerWe  (timerWe),
        .regAddr  (regAddr),
        .wData    (wData),
        .extAddr  (extAddr),
        .extWData (extWData),
        .extWe    (extWe),
        .timerSel (timerSel)
    );

    for (genvar g = 0; g < NUM_TIMERS; g++) begin : gTimer
        timer i_timer (
            .clk     (clk),
            .rstN    (rstN),
            .we      (timerWe[g]),
            .regAddr (regAddr),
            .wData   (wData),
            .rData   (timerRData[g]),
            .irq     (irq[g])
        );
    end

    busReadBack i_busReadBack (
        .clk        (clk),
        .rstN       (rstN),
        .timerSel   (timerSel),
        .timerRData (timerRData),
        .extRData   (extRData),
        .loadData   (loadData)
    );

endmodule

//--- hdl/regFile.sv
//**************************************************************************
// 32 x 32 register file, two read ports, one write port. Register 0 reads
// as zero. A same-cycle write is bypassed to the read ports.
//**************************************************************************
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rAddr1,
    input  logic [4:0]  rAddr2,
    input  logic        wEn,
    input  logic [4:0]  wAddr,
    input  logic [31:0] wData,
    output logic [31:0] rData1,
    output logic [31:0] rData2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wEn && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

    assign rData1 = (rAddr1 == 5'd0) ? 32'd0 :
                    (wEn && wAddr == rAddr1) ? wData : regs[rAddr1];
    assign rData2 = (rAddr2 == 5'd0) ? 32'd0 :
                    (wEn && wAddr == rAddr2) ? wData : regs[rAddr2];

    // Decode drops writes to $0 before they reach WB
    assert property (@(posedge clk) disable iff (!rstN) !(wEn && wAddr == 5'd0))
        else $error("write to register 0 reached the register file");

endmodule

//--- hdl/timer.sv
//**************************************************************************
// Countdown timer. The count register is read-only and loads from a preset
// write. One-shot mode holds irq until the next control write; reload mode
// pulses irq for one cycle and restarts from preset.
//**************************************************************************
module timer (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [3:0]  regAddr,
    input  logic [31:0] wData,
    output logic [31:0] rData,
    output logic        irq
);
    import busPkg::*;

    logic [1:0]  ctrl;
    logic [31:0] preset, count;
    logic        ctrlWr, presetWr, counting, hitZero, reload;

    assign ctrlWr   = we && regAddr == REG_CTRL;
    assign presetWr = we && regAddr == REG_PRESET;
    assign reload   = ctrl[CTRL_RELOAD_BIT];
    assign counting = ctrl[CTRL_EN_BIT] && !ctrlWr && !presetWr;
    assign hitZero  = counting && count == 32'd1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl   <= 2'b00;
            preset <= 32'd0;
            count  <= 32'd0;
        end else if (ctrlWr) begin
            ctrl <= wData[1:0];
        end else if (presetWr) begin
            preset <= wData;
            count  <= wData;
        end else if (counting && count != 32'd0) begin
            count <= count - 32'd1;
            if (hitZero && !reload) begin
                ctrl[CTRL_EN_BIT] <= 1'b0;
            end
        end else if (counting && reload) begin
            // Zero was reached last cycle
            count <= preset;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || ctrlWr) begin
            irq <= 1'b0;
        end else if (hitZero) begin
            irq <= 1'b1;
        end else if (reload) begin
            irq <= 1'b0;
        end
    end

    always_comb begin
        case (regAddr)
            REG_CTRL:   rData = {30'd0, ctrl};
            REG_PRESET: rData = preset;
            REG_COUNT:  rData = count;
            default:    rData = 32'd0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN) reload && irq |=> !irq)
        else $error("reload-mode irq held for two cycles");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the SoC testbench; the exit status is the test result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module tbMipsSoc -o simTb &&
./obj_dir/simTb || exit 1

//--- tb/tbMipsSoc.sv
//**************************************************************************
// Testbench for mipsSoc. The instruction ROM and the external word memory
// live here. Only byte addresses below 0x400 are modelled. A golden ISA
// model predicts the fetch order and every external write.
//**************************************************************************
module tbMipsSoc;
    import mipsPkg::*;
    import busPkg::*;

    localparam int          ROM_WORDS  = 64;
    localparam int          IRQ_MARGIN = 8;
    localparam int          RUN_LIMIT  = 3000;
    localparam logic [31:0] COUNT_ADDR = 32'h0000_0300;

    logic                  clk, rstN;
    logic [31:0]           instr, extRData, instrAddr, extAddr, extWData;
    logic                  extWe;
    logic [NUM_TIMERS-1:0] irq;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] extMem [256];
    logic [31:0] goldMem [256];
    logic [31:0] pcTrace [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] haltPc, lastAddr, p0, p1, firstCount;
    int          progLen, traceIdx, irqWait, irq1Pulses;
    logic        seenFetch, mark1, mark2, mark3, done, irq0Seen, prevIrq1;

    mipsSoc i_mipsSoc (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .extRData  (extRData),
        .instrAddr (instrAddr),
        .extAddr   (extAddr),
        .extWData  (extWData),
        .extWe     (extWe),
        .irq       (irq)
    );

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < 32'(ROM_WORDS)) ? rom[idx] : NOP_WORD;
    endfunction

    // Fill pattern uses the whole byte address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic isTimerAddr(input logic [31:0] addr);
        return addr >= TIMER_BASE && addr < TIMER_BASE + TIMER_STRIDE * 32'(NUM_TIMERS);
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                         input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Branch from ROM index b to index t
    function automatic logic [31:0] encBeq(input logic [4:0] rs, rt, input int b, t);
        return {OP_BEQ, rs, rt, 16'(t - b - 1)};
    endfunction

    function automatic logic [31:0] encJ(input int t);
        return {OP_J, 26'((RESET_PC + 32'(t) * 32'd4) >> 2)};
    endfunction

    task automatic put(input logic [31:0] w);
        rom[progLen] = w;
        progLen++;
    endtask

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp, act);
        failRun($sformatf("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act));
    endtask

    task automatic buildProgram(input logic [15:0] c1, c2);
        for (int k = 0; k < ROM_WORDS; k++) rom[k] = NOP_WORD;
        progLen = 0;
        put(encI(OP_ORI, 0, 1, c1));                       // 0
        put(encI(OP_LUI, 0, 2, c2));
        put(encR(1, 2, 3, FUNCT_ADDU));
        put(encR(3, 1, 4, FUNCT_SUBU));
        put(encI(OP_ORI, 4, 5, 16'h00F0));
        put(encI(OP_SW, 0, 3, 16'h0000));                  // 5
        put(encI(OP_SW, 0, 4, 16'h0004));
        put(encI(OP_SW, 0, 5, 16'h0008));
        put(encI(OP_LW, 0, 6, 16'h0040));
        put(encR(6, 1, 7, FUNCT_ADDU));
        put(encI(OP_SW, 0, 7, 16'h000C));                  // 10
        put(encBeq(1, 1, 11, 15));
        put(encI(OP_ORI, 0, 8, 16'h0011));
        put(encI(OP_SW, 0, 1, 16'h0010));
        put(encI(OP_SW, 0, 1, 16'h0014));
        put(encI(OP_SW, 0, 8, 16'h0018));                  // 15
        put(encBeq(1, 0, 16, 19));
        put(encI(OP_ORI, 0, 9, 16'h0022));
        put(encI(OP_SW, 0, 9, 16'h001C));
        put(encJ(22));
        put(encI(OP_ORI, 0, 10, 16'h0033));                // 20
        put(encI(OP_SW, 0, 1, 16'h0020));
        put(encI(OP_SW, 0, 10, 16'h0024));
        // Timer 0 one-shot, then a delay loop
        put(encI(OP_ORI, 0, 11, TIMER_BASE[15:0]));
        put(encI(OP_ORI, 0, 12, p0[15:0]));
        put(encI(OP_SW, 11, 12, 16'(REG_PRESET)));         // 25
        put(encI(OP_ORI, 0, 13, 16'h0001));
        put(encI(OP_SW, 11, 13, 16'(REG_CTRL)));
        put(encI(OP_SW, 0, 13, 16'h0200));
        put(encI(OP_ORI, 0, 14, 16'd10));
        put(encR(0, 13, 15, FUNCT_SUBU));                  // 30
        put(encR(14, 15, 14, FUNCT_ADDU));
        put(encBeq(14, 0, 32, 35));
        put(NOP_WORD);
        put(encBeq(0, 0, 34, 31));
        put(NOP_WORD);                                     // 35
        put(encI(OP_SW, 0, 13, 16'h0204));
        put(encI(OP_SW, 11, 0, 16'(REG_CTRL)));
        put(encI(OP_SW, 0, 13, 16'h0208));
        // Timer 1 in reload mode, count read back twice
        put(encI(OP_ORI, 0, 16, 16'(TIMER_BASE + TIMER_STRIDE)));
        put(encI(OP_ORI, 0, 17, p1[15:0]));                // 40
        put(encI(OP_SW, 16, 17, 16'(REG_PRESET)));
        put(encI(OP_ORI, 0, 18, 16'h0003));
        put(encI(OP_SW, 16, 18, 16'(REG_CTRL)));
        put(encI(OP_LW, 16, 19, 16'(REG_COUNT)));
        put(encI(OP_SW, 0, 19, 16'h0300));                 // 45
        put(encI(OP_LW, 16, 20, 16'(REG_COUNT)));
        put(encI(OP_SW, 0, 20, 16'h0304));
        put(encI(OP_SW, 0, 13, 16'h020C));
        put(encJ(49));
        put(NOP_WORD);                                     // 50
        haltPc = RESET_PC + 32'd196;
    endtask

    // Sequential ISA model with one delay slot; timer reads give zero
    task automatic runGolden();
        logic [31:0] regs [32];
        logic [31:0] pc, npc, nxt, w, immS, addr;
        logic [4:0]  rs, rt, rd;
        for (int k = 0; k < 32; k++) regs[k] = 32'd0;
        for (int k = 0; k < 256; k++) goldMem[k] = fillWord(32'(k) << 2);
        pc  = RESET_PC;
        npc = RESET_PC + 32'd4;
        for (int step = 0; step < RUN_LIMIT; step++) begin
            pcTrace.push_back(pc);
            if (pc == haltPc) break;
            w    = fetchWord(pc);
            rs   = w[25:21];
            rt   = w[20:16];
            rd   = w[15:11];
            immS = {{16{w[15]}}, w[15:0]};
            addr = regs[rs] + immS;
            nxt  = npc + 32'd4;
            case (w[31:26])
                OP_RTYPE: begin
                    if (w[5:0] == FUNCT_ADDU && rd != 0) regs[rd] = regs[rs] + regs[rt];
                    if (w[5:0] == FUNCT_SUBU && rd != 0) regs[rd] = regs[rs] - regs[rt];
                end
                OP_ORI: if (rt != 0) regs[rt] = regs[rs] | {16'd0, w[15:0]};
                OP_LUI: if (rt != 0) regs[rt] = {w[15:0], 16'd0};
                OP_LW: if (rt != 0) regs[rt] = isTimerAddr(addr) ? 32'd0 : goldMem[addr[9:2]];
                OP_SW: begin
                    if (!isTimerAddr(addr)) begin
                        goldMem[addr[9:2]] = regs[rt];
                        expAddr.push_back(addr);
                        expData.push_back(regs[rt]);
                    end
                end
                OP_BEQ: if (regs[rs] == regs[rt]) nxt = npc + (immS << 2);
                OP_J: nxt = {npc[31:28], w[25:0], 2'b00};
                default: ;
            endcase
            pc  = npc;
            npc = nxt;
        end
    endtask

    assign instr    = fetchWord(instrAddr);
    assign extRData = extMem[extAddr[9:2]];

    always @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < 256; k++) extMem[k] <= fillWord(32'(k) << 2);
        end else if (extWe) begin
            extMem[extAddr[9:2]] <= extWData;
        end
    end

    // All output checks sample at the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            if (!seenFetch) begin
                assert (!extWe && irq == '0) else failRun("extWe or irq high right after reset");
            end
            if (!seenFetch || instrAddr != lastAddr) begin
                if (traceIdx < pcTrace.size()) begin
                    assert (instrAddr == pcTrace[traceIdx])
                        else reportMismatch("instrAddr", pcTrace[traceIdx], instrAddr);
                    traceIdx++;
                end
                lastAddr  = instrAddr;
                seenFetch = 1'b1;
            end
            if (extWe) begin
                if (expAddr.size() == 0) begin
                    failRun("external write with no write left in the expected stream");
                end else begin
                    assert (extAddr == expAddr[0])
                        else reportMismatch("extAddr", expAddr[0], extAddr);
                    if (extAddr >= COUNT_ADDR) begin
                        assert (extWData <= p1) else reportMismatch("extWData", p1, extWData);
                        // Timer 1 keeps counting down between the two reads
                        if (extAddr == COUNT_ADDR) begin
                            firstCount = extWData;
                        end else begin
                            assert (extWData < firstCount)
                                else failRun("timer 1 count did not fall between two reads");
                        end
                    end else begin
                        assert (extWData == expData[0])
                            else reportMismatch("extWData", expData[0], extWData);
                    end
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
                case (extAddr)
                    32'h0200: mark1 = 1'b1;
                    32'h0204: begin
                        assert (irq0Seen) else failRun("irq[0] never rose before the clear");
                        mark2 = 1'b1;
                    end
                    32'h0208: begin
                        assert (!irq[0]) else failRun("irq[0] still high after control write");
                        mark3 = 1'b1;
                    end
                    32'h020C: done = 1'b1;
                    default: ;
                endcase
            end
            if (mark1 && !irq0Seen) begin
                if (irq[0]) begin
                    irq0Seen = 1'b1;
                end else begin
                    irqWait++;
                    if (irqWait > int'(p0) + IRQ_MARGIN) failRun("irq[0] did not rise in time");
                end
            end
            if (irq0Seen && !mark2) begin
                assert (irq[0]) else failRun("irq[0] dropped before its control write");
            end
            if (!mark3) begin
                assert (!irq[1]) else failRun("irq[1] rose while only timer 0 was active");
            end
            assert (!(irq[1] && prevIrq1)) else failRun("irq[1] high on two cycles in a row");
            if (irq[1] && !prevIrq1) begin
                irq1Pulses++;
            end
            prevIrq1 = irq[1];
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        logic [31:0] c1, c2;
        int          waitCycles;
        rstN       = 1'b0;
        seenFetch  = 1'b0;
        mark1      = 1'b0;
        mark2      = 1'b0;
        mark3      = 1'b0;
        done       = 1'b0;
        irq0Seen   = 1'b0;
        prevIrq1   = 1'b0;
        traceIdx   = 0;
        irqWait    = 0;
        irq1Pulses = 0;
        lastAddr   = 32'd0;
        firstCount = 32'd0;
        void'($urandom(49));
        c1   = $urandom | 32'd1;
        c2   = $urandom;
        p0   = 32'd3 + ($urandom % 32'd8);
        p1   = 32'd4 + ($urandom % 32'd8);
        buildProgram(c1[15:0], c2[15:0]);
        runGolden();
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
        waitCycles = 0;
        while (!done) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > RUN_LIMIT) failRun("timeout waiting for the final marker write");
        end
        waitCycles = 0;
        while (traceIdx < pcTrace.size()) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > 50) failRun("timeout waiting for the fetch to reach the halt loop");
        end
        // Let timer 1 wrap so its reload pulses are seen
        waitCycles = 0;
        while (irq1Pulses < 2) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > 3 * int'(p1) + IRQ_MARGIN) begin
                failRun("timeout waiting for timer 1 reload pulses");
            end
        end
        if (expAddr.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            failRun("expected external writes never appeared");
        end
    end

endmodule
